// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_dispatch_issue
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Verification failed
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BIN)
	@$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then \
		echo "simulator exited with status $$status"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
verilog/ooo_pkg.sv
verilog/operand_capture.sv
verilog/station_router.sv
verilog/reservation_station.sv
verilog/dispatch_issue.sv
tb/tb_dispatch_issue.sv

// ==== tb/tb_dispatch_issue.sv ====
module tb_dispatch_issue;
    import ooo_pkg::*;

    localparam int NUM_TESTS = 5;

    logic        clk;
    logic        rst;
    dispatch_t   dispatch;
    rob_lookup_t rob_rs1;
    rob_lookup_t rob_rs2;
    cdb_t        cdb;
    logic        dispatch_stall;
    issue_t      issue_alu;
    issue_t      issue_mul;
    issue_t      issue_br;
    integer      seed = 32'h50ec_c203;

    dispatch_issue dut0 (
        .clk(clk), .rst(rst), .dispatch(dispatch), .rob_rs1(rob_rs1), .rob_rs2(rob_rs2),
        .cdb(cdb), .dispatch_stall(dispatch_stall),
        .issue_alu(issue_alu), .issue_mul(issue_mul), .issue_br(issue_br)
    );

    always #50 clk = ~clk;

    task automatic report_failure();
        $display("Verification failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_data(string name, xlen_t got, xlen_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            report_failure();
        end
    endtask

    task automatic check_issue(string name, issue_t got, issue_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            report_failure();
        end
    endtask

    task automatic build_dispatch(output dispatch_t d, input order_t ord, input op_class_t cls,
                                  input rob_tag_t t1, input rob_tag_t t2);
        xlen_t r;
        d = '0;
        d.valid        = 1'b1;
        d.order        = ord;
        d.op_class     = cls;
        d.rs1_tag      = t1;
        d.rs2_tag      = t2;
        d.pc           = $random(seed);
        d.inst         = $random(seed);
        d.imm          = $random(seed);
        r              = $random(seed);
        d.funct        = r[3:0];
        d.rd_rob_tag   = r[8:4];
        d.rs1_arf_data = $random(seed);
        d.rs2_arf_data = $random(seed);
    endtask

    // arf, then rob, then a bus broadcast in the same cycle
    function automatic logic [32:0] pick_source(logic arf_ready, xlen_t arf_data,
                                                rob_lookup_t rob, cdb_t bus, rob_tag_t tag);
        if (arf_ready)
            return {1'b1, arf_data};
        if (rob.hit)
            return {1'b1, rob.data};
        if (bus.valid && bus.tag == tag)
            return {1'b1, bus.data};
        return '0;
    endfunction

    function automatic issue_t expect_entry(dispatch_t d, rob_lookup_t r1, rob_lookup_t r2,
                                            cdb_t bus);
        issue_t e;
        e            = '0;
        e.valid      = 1'b1;
        e.pc         = d.pc;
        e.order      = d.order;
        e.inst       = d.inst;
        e.op_class   = d.op_class;
        e.funct      = d.funct;
        e.imm        = d.imm;
        e.rd_rob_tag = d.rd_rob_tag;
        e.rs1_tag    = d.rs1_tag;
        e.rs2_tag    = d.rs2_tag;
        {e.rs1_ready, e.rs1_data} = pick_source(d.rs1_arf_ready, d.rs1_arf_data, r1, bus,
                                                d.rs1_tag);
        {e.rs2_ready, e.rs2_data} = pick_source(d.rs2_arf_ready, d.rs2_arf_data, r2, bus,
                                                d.rs2_tag);
        return e;
    endfunction

    function automatic issue_t issue_of(op_class_t cls);
        case (cls)
            class_mul: return issue_mul;
            class_br:  return issue_br;
            default:   return issue_alu;
        endcase
    endfunction

    // inputs land one edge later, the dispatch side holds off while stalled
    task automatic present(dispatch_t d, rob_lookup_t r1, rob_lookup_t r2, cdb_t bus);
        @(negedge clk);
        while (dispatch_stall) begin
            @(negedge clk);
        end
        @(posedge clk);
        dispatch <= d;
        rob_rs1  <= r1;
        rob_rs2  <= r2;
        cdb      <= bus;
    endtask

    task automatic idle_inputs();
        @(posedge clk);
        dispatch.valid <= 1'b0;
        rob_rs1.hit    <= 1'b0;
        rob_rs2.hit    <= 1'b0;
        cdb.valid      <= 1'b0;
    endtask

    task automatic send_cdb(rob_tag_t tag, xlen_t data);
        @(posedge clk);
        cdb <= {1'b1, tag, data};
        idle_inputs();
    endtask

    // starts right after the edge that sampled the inputs, which counts as edge 1
    task automatic wait_issue(op_class_t cls, int limit, output issue_t got, output int edges);
        issue_t cur;
        edges = 1;
        @(negedge clk);
        cur = issue_of(cls);
        while (!cur.valid) begin
            if (edges >= limit) begin
                $display("no issue on the %s output within %0d edges", cls.name(), limit);
                report_failure();
            end
            @(posedge clk);
            edges++;
            @(negedge clk);
            cur = issue_of(cls);
        end
        got = cur;
    endtask

    task automatic expect_quiet(int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check_bit("issue_alu.valid", issue_alu.valid, 1'b0);
            check_bit("issue_mul.valid", issue_mul.valid, 1'b0);
            check_bit("issue_br.valid", issue_br.valid, 1'b0);
            check_bit("dispatch_stall", dispatch_stall, 1'b0);
            @(posedge clk);
        end
    endtask

    task automatic dispatch_and_check(dispatch_t d, rob_lookup_t r1, rob_lookup_t r2, cdb_t bus,
                                      xlen_t rs1_exp, xlen_t rs2_exp);
        issue_t    got;
        issue_t    other;
        op_class_t cls;
        int        edges;
        present(d, r1, r2, bus);
        idle_inputs();
        wait_issue(d.op_class, 3, got, edges);
        check_bit("issue 3 edges after dispatch", edges == 3, 1'b1);
        for (int j = 0; j < NUM_CLASSES; j++) begin
            cls   = op_class_t'(j);
            other = issue_of(cls);
            if (cls != d.op_class)
                check_bit({"valid on ", cls.name()}, other.valid, 1'b0);
        end
        check_data("rs1_data", got.rs1_data, rs1_exp);
        check_data("rs2_data", got.rs2_data, rs2_exp);
        check_issue({"issue of ", d.op_class.name()}, got, expect_entry(d, r1, r2, bus));
    endtask

    task automatic test_reset();
        expect_quiet(6);
    endtask

    task automatic test_routing();
        dispatch_t d;
        for (int k = 0; k < NUM_CLASSES; k++) begin
            build_dispatch(d, order_t'(k + 1), op_class_t'(k), 5'd1, 5'd2);
            d.rs1_arf_ready = 1'b1;
            d.rs2_arf_ready = 1'b1;
            dispatch_and_check(d, '0, '0, '0, d.rs1_arf_data, d.rs2_arf_data);
        end
    endtask

    task automatic test_priority();
        dispatch_t   d;
        rob_lookup_t r1;
        rob_lookup_t r2;
        cdb_t        bus;
        // rob supplies rs1, a same-cycle broadcast supplies rs2
        build_dispatch(d, 8'd10, class_mul, 5'd3, 5'd4);
        r1  = {1'b1, xlen_t'($random(seed))};
        r2  = '0;
        bus = {1'b1, 5'd4, xlen_t'($random(seed))};
        dispatch_and_check(d, r1, r2, bus, r1.data, bus.data);
        // arf beats rob on rs1, rob beats the bus on rs2
        build_dispatch(d, 8'd11, class_br, 5'd5, 5'd6);
        d.rs1_arf_ready = 1'b1;
        r1  = {1'b1, xlen_t'($random(seed))};
        r2  = {1'b1, xlen_t'($random(seed))};
        bus = {1'b1, 5'd6, xlen_t'($random(seed))};
        dispatch_and_check(d, r1, r2, bus, d.rs1_arf_data, r2.data);
    endtask

    task automatic test_wakeup();
        dispatch_t d;
        issue_t    got;
        issue_t    exp;
        xlen_t     w;
        int        edges;
        build_dispatch(d, 8'd20, class_alu, 5'd7, 5'd9);
        d.rs1_arf_ready = 1'b1;
        present(d, '0, '0, '0);
        idle_inputs();
        expect_quiet(6);
        send_cdb(5'd8, xlen_t'($random(seed)));
        expect_quiet(4);
        w = $random(seed);
        send_cdb(5'd9, w);
        wait_issue(class_alu, 2, got, edges);
        // woken and issued at the edge that samples the matching tag
        check_bit("issue_alu on the wakeup edge", edges == 1, 1'b1);
        exp           = expect_entry(d, '0, '0, '0);
        exp.rs2_ready = 1'b1;
        exp.rs2_data  = w;
        check_data("issue_alu.rs2_data", got.rs2_data, w);
        check_issue("issue_alu", got, exp);
    endtask

    // four fill the station, the fifth waits in the router
    task automatic test_backpressure();
        dispatch_t ds[5];
        xlen_t     wk[5];
        issue_t    seen[$];
        issue_t    exp;
        int        exp_idx[5] = '{3, 2, 1, 0, 4};
        for (int k = 0; k < 5; k++) begin
            build_dispatch(ds[k], order_t'(30 + k), class_alu, 5'd1, rob_tag_t'(12 + k));
            ds[k].rs1_arf_ready = 1'b1;
            wk[k] = $random(seed);
            present(ds[k], '0, '0, '0);
        end
        idle_inputs();
        for (int c = 0; c < 10; c++) begin
            @(posedge clk);
            if (c < 5)
                cdb <= {1'b1, ds[4 - c].rs2_tag, wk[4 - c]};
            else
                cdb.valid <= 1'b0;
            @(negedge clk);
            if (c == 0)
                check_bit("dispatch_stall", dispatch_stall, 1'b1);
            check_bit("issue_mul.valid", issue_mul.valid, 1'b0);
            check_bit("issue_br.valid", issue_br.valid, 1'b0);
            if (issue_alu.valid)
                seen.push_back(issue_alu);
        end
        check_bit("dispatch_stall", dispatch_stall, 1'b0);
        if (seen.size() != 5) begin
            $display("expected 5 ALU issues after the wakeups, saw %0d", seen.size());
            report_failure();
        end
        // readiness first, then age among ready entries
        for (int i = 0; i < 5; i++) begin
            exp           = expect_entry(ds[exp_idx[i]], '0, '0, '0);
            exp.rs2_ready = 1'b1;
            exp.rs2_data  = wk[exp_idx[i]];
            check_issue("issue_alu", seen[i], exp);
        end
    endtask

    initial begin
        repeat (NUM_TESTS * 40) @(posedge clk);
        $display("watchdog expired before the tests finished");
        report_failure();
    end

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        dispatch = '0;
        rob_rs1  = '0;
        rob_rs2  = '0;
        cdb      = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_routing();
        test_priority();
        test_wakeup();
        test_backpressure();
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== verilog/dispatch_issue.sv ====
module dispatch_issue (
    input  logic                 clk,
    input  logic                 rst,
    input  ooo_pkg::dispatch_t   dispatch,
    input  ooo_pkg::rob_lookup_t rob_rs1,
    input  ooo_pkg::rob_lookup_t rob_rs2,
    input  ooo_pkg::cdb_t        cdb,
    output logic                 dispatch_stall,
    output ooo_pkg::issue_t      issue_alu,
    output ooo_pkg::issue_t      issue_mul,
    output ooo_pkg::issue_t      issue_br
);
    import ooo_pkg::*;

    rs_entry_t captured;
    rs_entry_t write_alu;
    rs_entry_t write_mul;
    rs_entry_t write_br;
    logic      free_alu;
    logic      free_mul;
    logic      free_br;

    operand_capture capture0 (
        .clk(clk), .rst(rst), .dispatch(dispatch), .rob_rs1(rob_rs1), .rob_rs2(rob_rs2),
        .cdb(cdb), .stall(dispatch_stall), .captured(captured)
    );

    // router stall also holds the capture register
    station_router router0 (
        .clk(clk), .rst(rst), .captured(captured), .cdb(cdb),
        .free_alu(free_alu), .free_mul(free_mul), .free_br(free_br),
        .write_alu(write_alu), .write_mul(write_mul), .write_br(write_br),
        .stall(dispatch_stall)
    );

    reservation_station #(.DEPTH(STATION_DEPTH)) alu_station (
        .clk(clk), .rst(rst), .write(write_alu), .cdb(cdb), .free(free_alu), .issue(issue_alu)
    );

    reservation_station #(.DEPTH(STATION_DEPTH)) mul_station (
        .clk(clk), .rst(rst), .write(write_mul), .cdb(cdb), .free(free_mul), .issue(issue_mul)
    );

    reservation_station #(.DEPTH(STATION_DEPTH)) br_station (
        .clk(clk), .rst(rst), .write(write_br), .cdb(cdb), .free(free_br), .issue(issue_br)
    );

endmodule

// ==== verilog/ooo_pkg.sv ====
package ooo_pkg;

    localparam int NUM_CLASSES   = 3;
    localparam int STATION_DEPTH = 4;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  rob_tag_t;
    typedef logic [7:0]  order_t;

    typedef enum logic [1:0] {
        class_alu = 2'd0,
        class_mul = 2'd1,
        class_br  = 2'd2
    } op_class_t;

    // renamed instruction from decode/rename
    typedef struct packed {
        logic      valid;
        xlen_t     pc;
        order_t    order;
        xlen_t     inst;
        op_class_t op_class;
        logic [3:0] funct;
        xlen_t     imm;
        rob_tag_t  rd_rob_tag;
        rob_tag_t  rs1_tag;
        logic      rs1_arf_ready;
        xlen_t     rs1_arf_data;
        rob_tag_t  rs2_tag;
        logic      rs2_arf_ready;
        xlen_t     rs2_arf_data;
    } dispatch_t;

    // producer written back, not yet committed
    typedef struct packed {
        logic  hit;
        xlen_t data;
    } rob_lookup_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        xlen_t    data;
    } cdb_t;

    typedef struct packed {
        logic       valid;
        xlen_t      pc;
        order_t     order;
        xlen_t      inst;
        op_class_t  op_class;
        logic [3:0] funct;
        xlen_t      imm;
        rob_tag_t   rd_rob_tag;
        rob_tag_t   rs1_tag;
        logic       rs1_ready;
        xlen_t      rs1_data;
        rob_tag_t   rs2_tag;
        logic       rs2_ready;
        xlen_t      rs2_data;
    } rs_entry_t;

    typedef rs_entry_t issue_t;

    // fill any missing source that the broadcast produces
    function automatic rs_entry_t cdb_wake(rs_entry_t e, cdb_t bus);
        rs_entry_t w;
        w = e;
        if (bus.valid && !e.rs1_ready && bus.tag == e.rs1_tag) begin
            w.rs1_ready = 1'b1;
            w.rs1_data  = bus.data;
        end
        if (bus.valid && !e.rs2_ready && bus.tag == e.rs2_tag) begin
            w.rs2_ready = 1'b1;
            w.rs2_data  = bus.data;
        end
        return w;
    endfunction

endpackage

// ==== verilog/operand_capture.sv ====
module operand_capture (
    input  logic                clk,
    input  logic                rst,
    input  ooo_pkg::dispatch_t   dispatch,
    input  ooo_pkg::rob_lookup_t rob_rs1,
    input  ooo_pkg::rob_lookup_t rob_rs2,
    input  ooo_pkg::cdb_t        cdb,
    input  logic                stall,
    output ooo_pkg::rs_entry_t   captured
);
    import ooo_pkg::*;

    rs_entry_t base_entry;
    rs_entry_t next_entry;

    always_comb begin
        base_entry.valid      = dispatch.valid;
        base_entry.pc         = dispatch.pc;
        base_entry.order      = dispatch.order;
        base_entry.inst       = dispatch.inst;
        base_entry.op_class   = dispatch.op_class;
        base_entry.funct      = dispatch.funct;
        base_entry.imm        = dispatch.imm;
        base_entry.rd_rob_tag = dispatch.rd_rob_tag;
        base_entry.rs1_tag    = dispatch.rs1_tag;
        base_entry.rs2_tag    = dispatch.rs2_tag;

        // arf first, then rob
        if (dispatch.rs1_arf_ready) begin
            base_entry.rs1_ready = 1'b1;
            base_entry.rs1_data  = dispatch.rs1_arf_data;
        end else if (rob_rs1.hit) begin
            base_entry.rs1_ready = 1'b1;
            base_entry.rs1_data  = rob_rs1.data;
        end else begin
            base_entry.rs1_ready = 1'b0;
            base_entry.rs1_data  = '0;
        end

        if (dispatch.rs2_arf_ready) begin
            base_entry.rs2_ready = 1'b1;
            base_entry.rs2_data  = dispatch.rs2_arf_data;
        end else if (rob_rs2.hit) begin
            base_entry.rs2_ready = 1'b1;
            base_entry.rs2_data  = rob_rs2.data;
        end else begin
            base_entry.rs2_ready = 1'b0;
            base_entry.rs2_data  = '0;
        end
    end

    // cdb last, only for sources still missing
    assign next_entry = cdb_wake(base_entry, cdb);

    always_ff @(posedge clk) begin
        if (rst) begin
            captured.valid <= 1'b0;
        end else if (stall) begin
            // held entry keeps listening to the bus
            captured <= cdb_wake(captured, cdb);
        end else begin
            captured <= next_entry;
        end
    end

    // the dispatch side honours the stall from the router
    dispatch_during_stall: assert property (
        @(posedge clk) disable iff (rst) stall |-> !dispatch.valid
    );

endmodule

// ==== verilog/reservation_station.sv ====
module reservation_station #(
    parameter int DEPTH = ooo_pkg::STATION_DEPTH
) (
    input  logic               clk,
    input  logic               rst,
    input  ooo_pkg::rs_entry_t write,
    input  ooo_pkg::cdb_t      cdb,
    output logic               free,
    output ooo_pkg::issue_t    issue
);
    import ooo_pkg::*;

    // oldest at index 0, valid slots packed at the bottom
    rs_entry_t slots      [DEPTH];
    rs_entry_t woken      [DEPTH];
    rs_entry_t next_slots [DEPTH];
    issue_t    issue_next;
    logic      found;
    int        sel_idx;
    logic      placed;

    assign free = !slots[DEPTH-1].valid;

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            woken[i] = cdb_wake(slots[i], cdb);
        end
    end

    // lowest index with both operands wins
    always_comb begin
        found   = 1'b0;
        sel_idx = 0;
        for (int i = 0; i < DEPTH; i++) begin
            if (!found && woken[i].valid && woken[i].rs1_ready && woken[i].rs2_ready) begin
                found   = 1'b1;
                sel_idx = i;
            end
        end
        issue_next       = woken[sel_idx];
        issue_next.valid = found;
    end

    // collapse over the issued slot, then append at the tail
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            next_slots[i] = woken[i];
        end
        if (found) begin
            for (int i = 0; i < DEPTH - 1; i++) begin
                if (i >= sel_idx) begin
                    next_slots[i] = woken[i+1];
                end
            end
            next_slots[DEPTH-1].valid = 1'b0;
        end

        placed = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            if (write.valid && !placed && !next_slots[i].valid) begin
                next_slots[i] = cdb_wake(write, cdb);
                placed        = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                slots[i].valid <= 1'b0;
            end
            issue.valid <= 1'b0;
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                slots[i] <= next_slots[i];
            end
            issue <= issue_next;
        end
    end

    // router must see free before writing
    write_when_full: assert property (
        @(posedge clk) disable iff (rst) write.valid |-> free
    );

    issue_operands_ready: assert property (
        @(posedge clk) disable iff (rst) issue.valid |-> (issue.rs1_ready && issue.rs2_ready)
    );

endmodule

// ==== verilog/station_router.sv ====
module station_router (
    input  logic               clk,
    input  logic               rst,
    input  ooo_pkg::rs_entry_t captured,
    input  ooo_pkg::cdb_t      cdb,
    input  logic               free_alu,
    input  logic               free_mul,
    input  logic               free_br,
    output ooo_pkg::rs_entry_t write_alu,
    output ooo_pkg::rs_entry_t write_mul,
    output ooo_pkg::rs_entry_t write_br,
    output logic               stall
);
    import ooo_pkg::*;

    rs_entry_t              held;
    rs_entry_t              cand;
    logic                   cand_free;
    logic [NUM_CLASSES-1:0] write_valids;

    // held entry goes before anything newer
    assign cand  = held.valid ? held : captured;
    assign stall = held.valid;

    always_comb begin
        case (cand.op_class)
            class_alu: cand_free = free_alu;
            class_mul: cand_free = free_mul;
            class_br:  cand_free = free_br;
            default:   cand_free = 1'b0;
        endcase
    end

    always_comb begin
        write_alu       = cand;
        write_mul       = cand;
        write_br        = cand;
        write_alu.valid = cand.valid && cand_free && cand.op_class == class_alu;
        write_mul.valid = cand.valid && cand_free && cand.op_class == class_mul;
        write_br.valid  = cand.valid && cand_free && cand.op_class == class_br;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            held.valid <= 1'b0;
        end else if (cand.valid && !cand_free) begin
            held <= cdb_wake(cand, cdb);
        end else begin
            held.valid <= 1'b0;
        end
    end

    assign write_valids = {write_br.valid, write_mul.valid, write_alu.valid};

    one_station_write: assert property (
        @(posedge clk) disable iff (rst) $onehot0(write_valids)
    );

endmodule
